/* div_top.f */
+incdir+hw
hw/div_pkg.sv
hw/div_operand_prep.sv
hw/div_ctl.sv
hw/div_datapath.sv
hw/div_result_sat.sv
hw/div_top.sv
bench/div_top_tb.sv

/* Bender.yml */
package:
  name: div_top

sources:
  - include_dirs:
      - hw
    files:
      - hw/div_pkg.sv
      - hw/div_operand_prep.sv
      - hw/div_ctl.sv
      - hw/div_datapath.sv
      - hw/div_result_sat.sv
      - hw/div_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/div_top_tb.sv

/* bench/div_top_tb.sv */
`timescale 1ns/100ps
`include "div_config.svh"

module div_top_tb
   import div_pkg::*;
();

   localparam int          CLK_PERIOD   = 20;
   localparam int          DONE_TIMEOUT = 4 * `DIV_ITER;   // Cycles allowed before done
   localparam logic [31:0] SEED         = 32'hef8;
   localparam int          WW           = `DIV_WORD_W;

   logic   rclk;
   logic   arst_n;
   logic   start;
   logic   div64;
   logic   is_signed;
   dword_t rs1;
   dword_t rs2;
   logic   y_wen;
   word_t  y_wdata;
   logic   busy;
   logic   done;
   logic   div_zero;
   dword_t result;
   word_t  y;

   int          errors       = 0;
   int          checks       = 0;
   int          tests_run    = 0;
   int          tests_failed = 0;
   word_t       y_model;          // Last value written to Y
   logic [31:0] rng_state;

   div_top dut_i (
      .rclk      (rclk),
      .arst_n    (arst_n),
      .start     (start),
      .div64     (div64),
      .is_signed (is_signed),
      .rs1       (rs1),
      .rs2       (rs2),
      .y_wen     (y_wen),
      .y_wdata   (y_wdata),
      .busy      (busy),
      .done      (done),
      .div_zero  (div_zero),
      .result    (result),
      .y         (y)
   );

   always #(CLK_PERIOD / 2) rclk = ~rclk;

   //////////////////////////////
   // Random numbers and checks
   //////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic draw_random(output dword_t v);
      rng_state = xorshift32(rng_state);
      v[63:32]  = rng_state;
      rng_state = xorshift32(rng_state);
      v[31:0]   = rng_state;
   endtask

   task automatic check_value(input string name, input dword_t got, input dword_t exp);
      checks++;
      if (got !== exp) begin
         $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int err0);
      tests_run++;
      if (errors != err0) begin
         tests_failed++;
      end
      $display("%s finished with %0d errors", name, errors - err0);
   endtask

   //////////////////////////////
   // Reference model
   //////////////////////////////

   // Divisor as the operation sees it, low word only on 32-bit ops
   function automatic dword_t effective_divisor(input logic d64, input logic sgn,
                                                input dword_t b);
      if (d64) begin
         return b;
      end
      return sgn ? {{WW{b[WW-1]}}, b[WW-1:0]} : {{WW{1'b0}}, b[WW-1:0]};
   endfunction

   function automatic dword_t expected_quotient(input logic d64, input logic sgn,
                                                input dword_t a_in, input dword_t b_in,
                                                input word_t y_val);
      dword_t a;
      dword_t b;
      dword_t q;
      logic   neg;
      a = d64 ? a_in : {y_val, a_in[WW-1:0]};   // Y above the low word
      b = effective_divisor(d64, sgn, b_in);
      if (b == '0) begin
         return '0;                              // Divide by zero clears
      end
      neg = sgn & (a[63] ^ b[63]);
      if (sgn & a[63]) a = -a;
      if (sgn & b[63]) b = -b;
      q = a / b;                                 // Magnitudes, truncated toward zero
      if (d64) begin
         return neg ? -q : q;                    // Modulo 2^64
      end
      if (!sgn) begin
         return (q > 64'hFFFF_FFFF) ? 64'h0000_0000_FFFF_FFFF : q;
      end
      if (!neg) begin
         return (q > 64'h7FFF_FFFF) ? 64'h0000_0000_7FFF_FFFF : q;
      end
      return (q > 64'h8000_0000) ? 64'hFFFF_FFFF_8000_0000 : -q;
   endfunction

   //////////////////////////////
   // Bus actions
   //////////////////////////////

   task automatic write_y_reg(input word_t v);
      @(posedge rclk);
      y_wen   <= 1'b1;
      y_wdata <= v;
      @(posedge rclk);
      y_wen   <= 1'b0;
      y_model = v;
      @(negedge rclk);
      check_value("y", y, v);                    // Readback one edge later
   endtask

   task automatic start_divide(input logic d64, input logic sgn, input dword_t a,
                               input dword_t b);
      @(posedge rclk);
      div64     <= d64;
      is_signed <= sgn;
      rs1       <= a;
      rs2       <= b;
      start     <= 1'b1;
      @(posedge rclk);                           // Edge 0, start sampled
      start     <= 1'b0;
   endtask

   // Counts edges after the last one passed, busy must hold until done
   task automatic wait_for_done(output int edges);
      edges = 0;
      @(negedge rclk);
      while (done !== 1'b1 && edges < DONE_TIMEOUT) begin
         check_value("busy", busy, 1'b1);
         @(negedge rclk);
         edges++;
      end
      if (done !== 1'b1) begin
         $display("Timeout: done did not arrive within %0d cycles", DONE_TIMEOUT);
         errors++;
      end
   endtask

   task automatic divide_and_check(input logic d64, input logic sgn, input dword_t a,
                                   input dword_t b);
      dword_t exp_q;
      logic   exp_zero;
      int     edges;
      exp_zero = (effective_divisor(d64, sgn, b) == '0);
      exp_q    = expected_quotient(d64, sgn, a, b, y_model);
      start_divide(d64, sgn, a, b);
      wait_for_done(edges);
      check_value("done latency", edges, exp_zero ? 1 : (`DIV_ITER + 1));
      check_value("result", result, exp_q);
      check_value("div_zero", div_zero, exp_zero);
      check_value("busy", busy, 1'b0);
      @(negedge rclk);
      check_value("done", done, 1'b0);           // Single cycle pulse
   endtask

   //////////////////////////////
   // Directed tests
   //////////////////////////////

   task automatic reset_values_test();
      int err0;
      err0 = errors;
      check_value("busy", busy, 1'b0);
      check_value("done", done, 1'b0);
      check_value("div_zero", div_zero, 1'b0);
      check_value("result", result, '0);
      check_value("y", y, '0);
      report_test("reset values", err0);
   endtask

   task automatic unsigned64_tests();
      int     err0;
      dword_t a;
      dword_t b;
      err0 = errors;
      divide_and_check(1'b1, 1'b0, 64'd100, 64'd7);
      divide_and_check(1'b1, 1'b0, '1, 64'd1);
      divide_and_check(1'b1, 1'b0, '1, '1);
      divide_and_check(1'b1, 1'b0, 64'd5, 64'd10);
      divide_and_check(1'b1, 1'b0, 64'h8000_0000_0000_0000, 64'd3);
      repeat (6) begin
         draw_random(a);
         draw_random(b);
         b = b >> a[5:0];                        // Spread the quotient sizes
         if (b == '0) b = 64'd1;
         divide_and_check(1'b1, 1'b0, a, b);
      end
      report_test("unsigned 64-bit", err0);
   endtask

   task automatic signed64_tests();
      int     err0;
      dword_t a;
      dword_t b;
      err0 = errors;
      divide_and_check(1'b1, 1'b1, 64'd100, 64'd7);
      divide_and_check(1'b1, 1'b1, -64'd100, 64'd7);
      divide_and_check(1'b1, 1'b1, 64'd100, -64'd7);
      divide_and_check(1'b1, 1'b1, -64'd100, -64'd7);
      divide_and_check(1'b1, 1'b1, -64'd7, 64'd100);
      divide_and_check(1'b1, 1'b1, 64'h8000_0000_0000_0000, '1);   // Wraps to itself
      divide_and_check(1'b1, 1'b1, 64'h8000_0000_0000_0000, 64'd1);
      repeat (4) begin
         draw_random(a);
         draw_random(b);
         b = b >>> a[5:0];
         if (b == '0) b = -64'd3;
         divide_and_check(1'b1, 1'b1, a, b);
      end
      report_test("signed 64-bit", err0);
   endtask

   task automatic unsigned32_tests();
      int     err0;
      dword_t a;
      dword_t b;
      err0 = errors;
      write_y_reg(32'h0);
      divide_and_check(1'b0, 1'b0, 64'h1234_5678_9ABC_DEF0, 64'hFFFF_0000_0000_0007);
      write_y_reg(32'h5);
      divide_and_check(1'b0, 1'b0, 64'h0, 64'h10);
      write_y_reg(32'h10);
      divide_and_check(1'b0, 1'b0, 64'h0, 64'h2);                 // Saturates
      repeat (4) begin
         draw_random(a);
         draw_random(b);
         write_y_reg(a[63:32] >> 8);
         divide_and_check(1'b0, 1'b0, a, b);
      end
      report_test("unsigned 32-bit", err0);
   endtask

   task automatic signed32_tests();
      int     err0;
      dword_t a;
      dword_t b;
      err0 = errors;
      write_y_reg(32'h0);
      divide_and_check(1'b0, 1'b1, 64'd100, 64'h0000_0000_FFFF_FFF9);
      divide_and_check(1'b0, 1'b1, 64'h8000_0000, 64'hFFFF_FFFF);  // -2^31 fits
      write_y_reg(32'hFFFF_FFFF);
      divide_and_check(1'b0, 1'b1, 64'hFFFF_FF9C, 64'd7);
      divide_and_check(1'b0, 1'b1, 64'h8000_0000, 64'd1);
      write_y_reg(32'h1);
      divide_and_check(1'b0, 1'b1, 64'h0, 64'd1);                 // Positive overflow
      divide_and_check(1'b0, 1'b1, 64'h0, 64'hFFFF_FFFF);         // Negative overflow
      repeat (4) begin
         draw_random(a);
         draw_random(b);
         write_y_reg({WW{a[WW-1]}});            // Dividend is a signed word
         divide_and_check(1'b0, 1'b1, a, b);
      end
      report_test("signed 32-bit", err0);
   endtask

   task automatic zero_divisor_tests();
      int err0;
      err0 = errors;
      write_y_reg(32'h3);
      divide_and_check(1'b1, 1'b0, 64'd55, 64'd0);
      divide_and_check(1'b1, 1'b1, -64'd55, 64'd0);
      divide_and_check(1'b0, 1'b0, 64'd55, 64'hABCD_0000_0000_0000);  // Low word zero
      divide_and_check(1'b0, 1'b1, 64'd55, 64'h1_0000_0000);
      divide_and_check(1'b1, 1'b0, 64'd55, 64'd5);                    // Clears div_zero
      report_test("divide by zero", err0);
   endtask

   task automatic busy_start_test();
      int     err0;
      int     edges;
      int     pulses;
      dword_t exp_q;
      err0  = errors;
      exp_q = expected_quotient(1'b1, 1'b0, 64'd1000, 64'd9, y_model);
      start_divide(1'b1, 1'b0, 64'd1000, 64'd9);
      repeat (10) @(posedge rclk);
      div64     <= 1'b0;                         // Second start with other operands
      is_signed <= 1'b1;
      rs1       <= 64'd77;
      rs2       <= 64'd0;
      start     <= 1'b1;
      @(posedge rclk);                           // Edge 11
      start     <= 1'b0;
      wait_for_done(edges);
      check_value("done latency", edges, `DIV_ITER + 1 - 11);
      check_value("result", result, exp_q);
      check_value("div_zero", div_zero, 1'b0);
      pulses = 0;
      repeat (`DIV_ITER + 5) begin               // No second run may follow
         @(negedge rclk);
         if (done === 1'b1) pulses++;
         check_value("busy", busy, 1'b0);
      end
      check_value("extra done pulses", pulses, 0);
      check_value("result", result, exp_q);
      report_test("start while busy", err0);
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial begin
      rclk      = 1'b0;
      arst_n    = 1'b0;
      start     = 1'b0;
      div64     = 1'b0;
      is_signed = 1'b0;
      rs1       = '0;
      rs2       = '0;
      y_wen     = 1'b0;
      y_wdata   = '0;
      y_model   = '0;
      rng_state = SEED;
      repeat (2) @(posedge rclk);
      arst_n <= 1'b1;
      @(negedge rclk);
      reset_values_test();
      unsigned64_tests();
      signed64_tests();
      unsigned32_tests();
      signed32_tests();
      zero_divisor_tests();
      busy_start_test();
      $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* hw/div_top.sv */
`timescale 1ns/100ps
`include "div_config.svh"

module div_top
   import div_pkg::*;
(
   input  logic   rclk,
   input  logic   arst_n,
   input  logic   start,
   input  logic   div64,
   input  logic   is_signed,
   input  dword_t rs1,
   input  dword_t rs2,
   input  logic   y_wen,
   input  word_t  y_wdata,
   output logic   busy,
   output logic   done,
   output logic   div_zero,
   output dword_t result,
   output word_t  y
);

   dword_t dividend_mag;      // Operand magnitudes into the datapath
   dword_t divisor_mag;
   logic   q_neg;             // Quotient sign for the fix-up
   logic   divisor_zero;
   logic   load;              // Controller strobes
   logic   step;
   logic   fix;
   logic   clr;
   dword_t quotient;          // Unsigned quotient magnitude

   //////////////////////////////
   // Operand side
   //////////////////////////////

   div_operand_prep operand_prep_i (
      .rclk         (rclk),
      .arst_n       (arst_n),
      .y_wen        (y_wen),
      .y_wdata      (y_wdata),
      .div64        (div64),
      .is_signed    (is_signed),
      .rs1          (rs1),
      .rs2          (rs2),
      .y            (y),
      .dividend_mag (dividend_mag),
      .divisor_mag  (divisor_mag),
      .q_neg        (q_neg),
      .divisor_zero (divisor_zero)
   );

   div_ctl ctl_i (
      .rclk         (rclk),
      .arst_n       (arst_n),
      .start        (start),
      .divisor_zero (divisor_zero),
      .busy         (busy),
      .done         (done),
      .div_zero     (div_zero),
      .load         (load),
      .step         (step),
      .fix          (fix),
      .clr          (clr)
   );

   //////////////////////////////
   // Divide and result
   //////////////////////////////

   div_datapath datapath_i (
      .rclk         (rclk),
      .arst_n       (arst_n),
      .load         (load),
      .step         (step),
      .dividend_mag (dividend_mag),
      .divisor_mag  (divisor_mag),
      .quotient     (quotient)
   );

   div_result_sat result_sat_i (
      .rclk         (rclk),
      .arst_n       (arst_n),
      .load         (load),
      .fix          (fix),
      .clr          (clr),
      .div64        (div64),
      .is_signed    (is_signed),
      .q_neg        (q_neg),
      .quotient     (quotient),
      .result       (result)
   );

endmodule

/* hw/div_result_sat.sv */
`timescale 1ns/100ps
`include "div_config.svh"

module div_result_sat
   import div_pkg::*;
(
   input  logic   rclk,
   input  logic   arst_n,
   input  logic   load,
   input  logic   fix,
   input  logic   clr,
   input  logic   div64,
   input  logic   is_signed,
   input  logic   q_neg,
   input  dword_t quotient,
   output dword_t result
);

   localparam int WW = `DIV_WORD_W;

   logic   div64_q;       // Mode as seen at start
   logic   signed_q;
   logic   q_neg_q;
   dword_t sval;          // Quotient with sign applied, modulo 2^64
   logic   u32_fit;       // Upper 32 bits clear
   logic   s32_fit;       // Upper 33 bits all equal
   dword_t res_next;

   // Mode latch, operands may change after start
   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         div64_q  <= 1'b0;
         signed_q <= 1'b0;
         q_neg_q  <= 1'b0;
      end else if (load) begin
         div64_q  <= div64;
         signed_q <= is_signed;
         q_neg_q  <= q_neg;
      end
   end

   //////////////////////////////
   // Sign and saturation
   //////////////////////////////

   assign sval    = q_neg_q ? (~quotient + 1'b1) : quotient;
   assign u32_fit = ~|quotient[2*WW-1:WW];
   assign s32_fit = (&sval[2*WW-1:WW-1]) | (~|sval[2*WW-1:WW-1]);

   always_comb begin
      if (div64_q) begin
         res_next = sval;                                  // Truncated toward zero
      end else if (!signed_q) begin
         res_next = u32_fit ? {{WW{1'b0}}, quotient[WW-1:0]}
                            : {{WW{1'b0}}, {WW{1'b1}}};    // 0xFFFFFFFF
      end else if (s32_fit) begin
         res_next = {{WW{sval[WW-1]}}, sval[WW-1:0]};      // Sign extended
      end else if (q_neg_q) begin
         res_next = {{(WW+1){1'b1}}, {(WW-1){1'b0}}};      // Most negative word
      end else begin
         res_next = {{(WW+1){1'b0}}, {(WW-1){1'b1}}};      // 0x7FFFFFFF
      end
   end

   // Result register, held until the next finish
   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         result <= '0;
      end else if (clr) begin
         result <= '0;                                      // Divide by zero
      end else if (fix) begin
         result <= res_next;
      end
   end

endmodule

/* hw/div_datapath.sv */
`timescale 1ns/100ps
`include "div_config.svh"

module div_datapath
   import div_pkg::*;
(
   input  logic   rclk,
   input  logic   arst_n,
   input  logic   load,
   input  logic   step,
   input  dword_t dividend_mag,
   input  dword_t divisor_mag,
   output dword_t quotient
);

   localparam int DW = `DIV_DWORD_W;

   logic [2*DW-1:0] d_q;          // Partial remainder above, dividend/quotient below
   dword_t          x_q;          // Divisor magnitude
   logic [DW:0]     adder_a;      // Remainder after the left shift, 65 bits
   logic [DW:0]     adder_b;      // Inverted divisor
   logic [DW+1:0]   adder_sum;    // Carry out on top
   logic            new_q;        // Quotient bit of this step
   dword_t          rem_next;     // Restored or reduced remainder

   //////////////////////////////
   // Subtract adder
   //////////////////////////////

   // Shift left one, top bit moves into the adder's 65th bit
   assign adder_a = d_q[2*DW-1:DW-1];
   assign adder_b = ~{1'b0, x_q};

   // a - x as a + ~x + 1
   assign adder_sum = {1'b0, adder_a} + {1'b0, adder_b} + 1'b1;
   assign new_q     = adder_sum[DW+1];   // No borrow, divisor fits

   // Keep the difference only when the divisor fit
   assign rem_next = new_q ? adder_sum[DW-1:0] : adder_a[DW-1:0];

   //////////////////////////////
   // D and X registers
   //////////////////////////////

   always_ff @(posedge rclk) begin
      if (load) begin
         d_q <= {{DW{1'b0}}, dividend_mag};   // Remainder starts at zero
         x_q <= divisor_mag;
      end else if (step) begin
         // Quotient bit enters at the bottom as the dividend shifts out
         d_q <= {rem_next, d_q[DW-2:0], new_q};
      end
   end

   assign quotient = d_q[DW-1:0];            // Final after the last step

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Controller never steps while loading
   load_step_a: assert property (
      @(posedge rclk) disable iff (!arst_n) !(load && step)
   ) else $error("step issued in the load cycle");

endmodule

/* hw/div_ctl.sv */
`timescale 1ns/100ps
`include "div_config.svh"

module div_ctl
   import div_pkg::*;
(
   input  logic rclk,
   input  logic arst_n,
   input  logic start,
   input  logic divisor_zero,
   output logic busy,
   output logic done,
   output logic div_zero,
   output logic load,
   output logic step,
   output logic fix,
   output logic clr
);

   // Index of the final step
   localparam logic [`DIV_CNT_W-1:0] LAST_STEP = `DIV_CNT_W'(`DIV_ITER - 1);

   div_state_t             state;
   logic [`DIV_CNT_W-1:0]  cnt;       // Steps taken so far
   logic                   zero_q;    // Divisor was zero at load

   //////////////////////////////
   // Strobes
   //////////////////////////////

   assign load = start & (state == idle);     // Start ignored while busy
   assign step = (state == run);
   // Enum value shares the strobe's name, so scope it
   assign fix  = (state == div_pkg::fix) & ~zero_q;
   assign clr  = (state == div_pkg::fix) & zero_q;
   assign busy = (state != idle);

   //////////////////////////////
   // FSM and step counter
   //////////////////////////////

   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= idle;
         cnt      <= '0;
         zero_q   <= 1'b0;
         done     <= 1'b0;
         div_zero <= 1'b0;
      end else begin
         done <= fix | clr;                 // One cycle after the write strobe
         if (fix | clr) begin
            div_zero <= clr;                 // Held until the next finish
         end
         case (state)
            idle: begin
               if (load) begin
                  cnt    <= '0;
                  zero_q <= divisor_zero;    // Sampled only with start
                  // Zero divisor skips the steps
                  state  <= divisor_zero ? div_pkg::fix : run;
               end
            end
            run: begin
               cnt <= cnt + 1'b1;
               if (cnt == LAST_STEP) begin
                  state <= div_pkg::fix;     // 64th step this cycle
               end
            end
            default: begin
               state <= idle;                // Result written, back to idle
            end
         endcase
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Result write only after the full step count
   step_count_a: assert property (
      @(posedge rclk) disable iff (!arst_n) fix |-> (cnt == `DIV_ITER)
   ) else $error("fix issued before all divide steps were taken");

   // done is a single-cycle pulse
   done_pulse_a: assert property (
      @(posedge rclk) disable iff (!arst_n) done |=> !done
   ) else $error("done held for more than one cycle");

endmodule

/* hw/div_operand_prep.sv */
`timescale 1ns/100ps
`include "div_config.svh"

module div_operand_prep
   import div_pkg::*;
(
   input  logic   rclk,
   input  logic   arst_n,
   input  logic   y_wen,
   input  word_t  y_wdata,
   input  logic   div64,
   input  logic   is_signed,
   input  dword_t rs1,
   input  dword_t rs2,
   output word_t  y,
   output dword_t dividend_mag,
   output dword_t divisor_mag,
   output logic   q_neg,
   output logic   divisor_zero
);

   dword_t dividend;            // Full 64-bit dividend
   dword_t divisor;             // Sign/zero extended divisor
   logic   dividend_neg;        // Signed op, dividend below zero
   logic   divisor_neg;         // Signed op, divisor below zero
   logic   rs2_sext;            // Fill for upper divisor half

   //////////////////////////////
   // Y register
   //////////////////////////////

   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         y <= '0;
      end else if (y_wen) begin
         y <= y_wdata;           // Writable any time
      end
   end

   //////////////////////////////
   // Operand assembly
   //////////////////////////////

   // 32-bit ops take Y as the upper dividend word
   assign dividend = div64 ? rs1 : {y, rs1[`DIV_WORD_W-1:0]};

   // Only the low word of rs2 counts on 32-bit ops
   assign rs2_sext = is_signed & rs2[`DIV_WORD_W-1];
   assign divisor  = div64 ? rs2
                           : {{`DIV_WORD_W{rs2_sext}}, rs2[`DIV_WORD_W-1:0]};

   // Sign bits, ignored for unsigned
   assign dividend_neg = is_signed & dividend[`DIV_DWORD_W-1];
   assign divisor_neg  = is_signed & divisor[`DIV_DWORD_W-1];

   // Magnitudes, most negative value maps to 2^63 unsigned
   assign dividend_mag = dividend_neg ? (~dividend + 1'b1) : dividend;
   assign divisor_mag  = divisor_neg ? (~divisor + 1'b1) : divisor;

   assign q_neg        = dividend_neg ^ divisor_neg;   // Quotient sign
   assign divisor_zero = ~|divisor;                     // Low word only on 32-bit ops

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Y stays known once out of reset
   y_known_a: assert property (
      @(posedge rclk) disable iff (!arst_n) !$isunknown(y)
   ) else $error("Y register holds unknown bits");

endmodule

/* hw/div_pkg.sv */
`include "div_config.svh"

//////////////////////////////
// Shared divider types
//////////////////////////////

package div_pkg;

   // Full-width operand / result
   typedef logic [`DIV_DWORD_W-1:0] dword_t;

   // Y register and its write data
   typedef logic [`DIV_WORD_W-1:0] word_t;

   // Controller states
   // idle  waits for start
   // run   one restoring step per cycle
   // fix   result write, or clear on zero divisor
   typedef enum logic [1:0] {
      idle = 2'd0,
      run  = 2'd1,
      fix  = 2'd2
   } div_state_t;

endpackage

/* hw/div_config.svh */
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

//////////////////////////////
// Divider sizes
//////////////////////////////

// Operands, magnitudes, quotient and result
`define DIV_DWORD_W 64

// Y register, also the width of the 32-bit ops
`define DIV_WORD_W 32

// One quotient bit per step
`define DIV_ITER 64

// Step counter, wide enough for DIV_ITER
`define DIV_CNT_W 7

`endif
